// File: hw/dz_pkg.sv
package dz_pkg;

    // digit and row codes
    localparam int DIGIT_W = 3;
    localparam int ROW_W   = 3;

    // rows, and columns per colour
    localparam int MATRIX_N = 8;

    localparam logic [DIGIT_W-1:0] START_DIGIT = 3'd5;
    localparam logic [DIGIT_W-1:0] BLANK_DIGIT = 3'd0;

    // idle until start, then count down to blank
    typedef enum logic
    {
        SEQ_IDLE  = 1'b0,
        SEQ_COUNT = 1'b1
    } seq_state_e;

endpackage

// File: hw/glyph_if.sv
`timescale 1ns/1ps

interface glyph_if;

    logic [dz_pkg::DIGIT_W-1:0]  digit;
    logic [dz_pkg::ROW_W-1:0]    row_idx;
    logic [dz_pkg::MATRIX_N-1:0] red;     // column bits, red led
    logic [dz_pkg::MATRIX_N-1:0] green;   // column bits, green led

    // display side asks, rom answers in the same cycle
    modport requester (output digit, output row_idx, input red, input green);
    modport tbl (input digit, input row_idx, output red, output green);

endinterface

// File: hw/dz_glyph_rom.sv
`timescale 1ns/1ps

module dz_glyph_rom
(
    glyph_if.tbl g
);

    logic [dz_pkg::MATRIX_N-1:0] bmp;
    logic                        yellow;

    // glyph shape, row 0 is always blank
    always_comb
    begin
        bmp = '0;
        case (g.digit)
            3'd5:
            begin
                case (g.row_idx)
                    3'd1:       bmp = 8'b0111_1110;
                    3'd2:       bmp = 8'b0110_0000;
                    3'd3:       bmp = 8'b0111_1100;
                    3'd4, 3'd5: bmp = 8'b0000_0110;
                    3'd6:       bmp = 8'b0110_0110;
                    3'd7:       bmp = 8'b0011_1100;
                    default:    bmp = 8'b0000_0000;
                endcase
            end
            3'd4:
            begin
                case (g.row_idx)
                    3'd1:       bmp = 8'b0000_1100;
                    3'd2:       bmp = 8'b0001_1100;
                    3'd3:       bmp = 8'b0010_1100;
                    3'd4:       bmp = 8'b0100_1100;
                    3'd5:       bmp = 8'b0111_1110;
                    3'd6, 3'd7: bmp = 8'b0000_1100;
                    default:    bmp = 8'b0000_0000;
                endcase
            end
            3'd3:
            begin
                case (g.row_idx)
                    3'd1:       bmp = 8'b0011_1100;
                    3'd2:       bmp = 8'b0110_0110;
                    3'd3:       bmp = 8'b0000_0110;
                    3'd4:       bmp = 8'b0001_1100;
                    3'd5:       bmp = 8'b0000_0110;
                    3'd6:       bmp = 8'b0110_0110;
                    3'd7:       bmp = 8'b0011_1100;
                    default:    bmp = 8'b0000_0000;
                endcase
            end
            3'd2:
            begin
                case (g.row_idx)
                    3'd1:       bmp = 8'b0011_1100;
                    3'd2:       bmp = 8'b0110_0110;
                    3'd3:       bmp = 8'b0000_0110;
                    3'd4:       bmp = 8'b0000_1100;
                    3'd5:       bmp = 8'b0011_0000;
                    3'd6:       bmp = 8'b0110_0000;
                    3'd7:       bmp = 8'b0111_1110;
                    default:    bmp = 8'b0000_0000;
                endcase
            end
            3'd1:
            begin
                case (g.row_idx)
                    3'd1, 3'd2: bmp = 8'b0001_1000;
                    3'd3:       bmp = 8'b0011_1000;
                    3'd4, 3'd5: bmp = 8'b0001_1000;
                    3'd6:       bmp = 8'b0110_0000;
                    3'd7:       bmp = 8'b0111_1110;
                    default:    bmp = 8'b0000_0000;
                endcase
            end
            default:
            begin
                bmp = '0;   // blank digit and unused codes
            end
        endcase
    end

    // the last three digits light both colours, which reads as yellow
    assign yellow = (g.digit >= 3'd1) && (g.digit <= 3'd3);

    assign g.red   = bmp;
    assign g.green = yellow ? bmp : '0;

endmodule

// File: hw/dz_show.sv
`timescale 1ns/1ps

module dz_show
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic [dz_pkg::DIGIT_W-1:0]  digit,
    output logic [dz_pkg::MATRIX_N-1:0] row,
    output logic [dz_pkg::MATRIX_N-1:0] colr,
    output logic [dz_pkg::MATRIX_N-1:0] colg,
    glyph_if.requester                  g
);

    logic [dz_pkg::DIGIT_W-1:0]  dz_num;
    logic [dz_pkg::ROW_W-1:0]    row_cnt;
    logic [dz_pkg::MATRIX_N-1:0] row_dec;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            dz_num <= dz_pkg::BLANK_DIGIT;
        else
            dz_num <= digit;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            row_cnt <= '0;
        else
            row_cnt <= row_cnt + 1'b1;   // wraps 7 -> 0
    end

    assign g.digit   = dz_num;
    assign g.row_idx = row_cnt;

    always_comb
    begin
        row_dec          = '0;
        row_dec[row_cnt] = 1'b1;
    end

    // row select and the glyph for it leave together
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row  <= '0;
            colr <= '0;
            colg <= '0;
        end
        else
        begin
            row  <= row_dec;
            colr <= g.red;
            colg <= g.green;
        end
    end

    a_row_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(row));

    // once scanning, the lit row walks up one step per clock
    a_row_walk: assert property (@(posedge clk) disable iff (rst)
        (row != '0) |=> (row == {$past(row[dz_pkg::MATRIX_N-2:0]),
                                 $past(row[dz_pkg::MATRIX_N-1])}));

endmodule

// File: hw/countdown_seq.sv
`timescale 1ns/1ps

module countdown_seq
#(
    parameter int TICK_CYCLES = 64
)
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    output logic [dz_pkg::DIGIT_W-1:0] digit,
    output logic                       done
);

    dz_pkg::seq_state_e state;
    logic [31:0]        hold_cnt;
    logic               hold_end;

    assign hold_end = (hold_cnt == 32'(TICK_CYCLES - 1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state    <= dz_pkg::SEQ_IDLE;
            hold_cnt <= '0;
            digit    <= dz_pkg::BLANK_DIGIT;
            done     <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                dz_pkg::SEQ_IDLE:
                begin
                    if (start)
                    begin
                        state    <= dz_pkg::SEQ_COUNT;
                        hold_cnt <= '0;
                        digit    <= dz_pkg::START_DIGIT;
                    end
                end
                dz_pkg::SEQ_COUNT:
                begin
                    // start is not looked at here
                    if (hold_end)
                    begin
                        hold_cnt <= '0;
                        digit    <= digit - 1'b1;
                        if (digit == 3'd1)
                        begin
                            done  <= 1'b1;
                            state <= dz_pkg::SEQ_IDLE;
                        end
                    end
                    else
                    begin
                        hold_cnt <= hold_cnt + 32'd1;
                    end
                end
                default:
                begin
                    state <= dz_pkg::SEQ_IDLE;
                end
            endcase
        end
    end

    a_digit_range: assert property (@(posedge clk) disable iff (rst)
        digit <= dz_pkg::START_DIGIT);

    // done only on the step from 1 to blank
    a_done_blank: assert property (@(posedge clk) disable iff (rst)
        done |-> (digit == dz_pkg::BLANK_DIGIT) && ($past(digit) == 3'd1));

endmodule

// File: hw/dz_countdown_top.sv
`timescale 1ns/1ps

module dz_countdown_top
#(
    parameter int TICK_CYCLES = 64
)
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,
    output logic [dz_pkg::DIGIT_W-1:0]  digit,
    output logic                        done,
    output logic [dz_pkg::MATRIX_N-1:0] row,
    output logic [dz_pkg::MATRIX_N-1:0] colr,
    output logic [dz_pkg::MATRIX_N-1:0] colg
);

    glyph_if gi ();

    countdown_seq #(
        .TICK_CYCLES (TICK_CYCLES)
    ) seq0 (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .digit (digit),   // also feeds the display
        .done  (done)
    );

    dz_show show0 (
        .clk   (clk),
        .rst   (rst),
        .digit (digit),
        .row   (row),
        .colr  (colr),
        .colg  (colg),
        .g     (gi.requester)
    );

    dz_glyph_rom rom0 (
        .g (gi.tbl)
    );

endmodule

// File: sim/tb_dz_countdown.sv
`timescale 1ns/1ps

module tb_dz_countdown;

    parameter int TICK_CYCLES = 64;

    localparam int GLYPH_LINES = 40;   // digits 5..1 with eight rows each
    localparam int MAX_RUNS    = 16;

    logic       clk;
    logic       rst;
    logic       start;
    logic [2:0] digit;
    logic       done;
    logic [7:0] row;
    logic [7:0] colr;
    logic [7:0] colg;

    logic [15:0] tdata [0:255];
    logic [7:0]  glyph_r [0:63];      // indexed by {digit, row}
    logic [7:0]  glyph_g [0:63];
    int          gaps [0:MAX_RUNS-1];
    int          n_runs;

    logic [31:0] lfsr;
    int          cycle_cnt = 0;
    int          limit_cycles = 0;
    int          n_pass = 0;
    int          n_fail = 0;

    // monitor state
    int          mon_n = 0;
    int          b;
    int          row_err = 0;
    int          glyph_err = 0;
    int          colour_err = 0;
    logic [2:0]  d1 = '0;
    logic [2:0]  d2 = '0;
    logic [2:0]  mon_idx;
    logic [7:0]  prev_row = '0;
    logic [7:0]  exp_row;
    logic [7:0]  exp_r;
    logic [7:0]  exp_g;

    dz_countdown_top #(
        .TICK_CYCLES (TICK_CYCLES)
    ) dut0 (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .digit (digit),
        .done  (done),
        .row   (row),
        .colr  (colr),
        .colg  (colg)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
        cycle_cnt <= cycle_cnt + 1;

    // 32-bit fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [7:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++)
        begin
            v    = {v[6:0], lfsr[31]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic report_mismatch(input string name, input logic [7:0] got,
                                   input logic [7:0] exp);
        $display("CHECK FAILED %s: got 0x%02h, expected 0x%02h at cycle %0d",
                 name, got, exp, cycle_cnt);
    endtask

    task automatic report_test(input string name, input int errs);
        if (errs == 0)
            n_pass++;
        else
            n_fail++;
        $display("test %-36s %s (%0d errors)", name, (errs == 0) ? "ok" : "FAILED", errs);
    endtask

    task automatic check_all_zero(inout int errs);
        if (digit !== 3'd0)
        begin
            report_mismatch("digit", 8'(digit), 8'h00);
            errs++;
        end
        if (done !== 1'b0)
        begin
            report_mismatch("done", 8'(done), 8'h00);
            errs++;
        end
        if (row !== 8'h00)
        begin
            report_mismatch("row", row, 8'h00);
            errs++;
        end
        if (colr !== 8'h00)
        begin
            report_mismatch("colr", colr, 8'h00);
            errs++;
        end
        if (colg !== 8'h00)
        begin
            report_mismatch("colg", colg, 8'h00);
            errs++;
        end
    endtask

    task automatic check_digit(input logic [2:0] exp_d, input logic exp_done, inout int errs);
        if (digit !== exp_d)
        begin
            report_mismatch("digit", 8'(digit), 8'(exp_d));
            errs++;
        end
        if (done !== exp_done)
        begin
            report_mismatch("done", 8'(done), 8'(exp_done));
            errs++;
        end
    endtask

    // one countdown with random extra starts followed by the idle gap
    task automatic run_countdown(input int gap, output int errs, output int pulses);
        int         i;
        logic [7:0] pick;
        errs   = 0;
        pulses = 0;
        @(posedge clk);
        start <= 1'b1;
        @(negedge clk);
        check_digit(3'd0, 1'b0, errs);   // start not yet sampled
        @(posedge clk);
        start <= 1'b0;
        for (i = 0; i < 5 * TICK_CYCLES; i++)
        begin
            @(negedge clk);
            check_digit(3'(5 - i / TICK_CYCLES), 1'b0, errs);
            rand_bits(3, pick);
            @(posedge clk);
            // a pulse on the last edge would land in idle
            if (i < 5 * TICK_CYCLES - 1 && pick == 8'd0)
            begin
                start <= 1'b1;
                pulses++;
            end
            else
                start <= 1'b0;
        end
        @(negedge clk);
        check_digit(3'd0, 1'b1, errs);
        for (i = 0; i < gap; i++)
        begin
            @(posedge clk);
            @(negedge clk);
            check_digit(3'd0, 1'b0, errs);
        end
    endtask

    // row scan, glyph and colour checks on every cycle out of reset
    always @(negedge clk)
    begin
        if (!rst)
        begin
            if (mon_n != 0)
            begin
                exp_row = (prev_row == 8'h00) ? 8'h01 : {prev_row[6:0], prev_row[7]};
                if (row !== exp_row)
                begin
                    report_mismatch("row", row, exp_row);
                    row_err++;
                end
            end
            mon_idx = '0;
            for (b = 0; b < 8; b++)
                if (row[b] === 1'b1)
                    mon_idx = 3'(b);
            exp_r = (row == 8'h00) ? 8'h00 : glyph_r[{d2, mon_idx}];
            exp_g = (row == 8'h00) ? 8'h00 : glyph_g[{d2, mon_idx}];
            if (colr !== exp_r)
            begin
                report_mismatch("colr", colr, exp_r);
                glyph_err++;
            end
            if (colg !== exp_g)
            begin
                report_mismatch("colg", colg, exp_g);
                glyph_err++;
            end
            if ((d2 == 3'd5 || d2 == 3'd4) && colg !== 8'h00)
            begin
                report_mismatch("colg", colg, 8'h00);   // red only
                colour_err++;
            end
            if (d2 >= 3'd1 && d2 <= 3'd3 && colg !== colr)
            begin
                report_mismatch("colg", colg, colr);    // yellow
                colour_err++;
            end
            d2       = d1;
            d1       = digit;
            prev_row = row;
            mon_n++;
        end
    end

    initial
    begin
        wait (limit_cycles != 0);
        wait (cycle_cnt >= limit_cycles);
        $display("timeout: the countdown runs did not finish within %0d cycles", limit_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial
    begin
        int         e;
        int         k;
        int         errs;
        int         pulses;
        int         max_gap;
        logic [5:0] gi;

        rst   = 1'b1;
        start = 1'b0;
        lfsr  = 32'h0de9a65f;
        for (e = 0; e < 64; e++)
        begin
            glyph_r[e] = '0;
            glyph_g[e] = '0;
        end
        $readmemh("sim/dz_testdata.txt", tdata);
        for (e = 0; e < GLYPH_LINES; e++)
        begin
            gi          = {tdata[4*e][2:0], tdata[4*e+1][2:0]};
            glyph_r[gi] = tdata[4*e+2][7:0];
            glyph_g[gi] = tdata[4*e+3][7:0];
        end
        n_runs  = 0;
        max_gap = 0;
        if (!$isunknown(tdata[4*GLYPH_LINES]) && !$isunknown(tdata[4*GLYPH_LINES-1]))
            n_runs = int'(tdata[4*GLYPH_LINES]);
        if (n_runs == 0)
            report_test("test data: file missing, short or without runs", 1);
        if (n_runs > MAX_RUNS)
            n_runs = MAX_RUNS;
        for (k = 0; k < n_runs; k++)
        begin
            gaps[k] = int'(tdata[4*GLYPH_LINES+1+k]);
            if (gaps[k] > max_gap)
                max_gap = gaps[k];
        end
        limit_cycles = n_runs * (5 * TICK_CYCLES + max_gap + 16) + 100;

        // outputs stay quiet through 4 reset cycles and the first cycle after them
        errs = 0;
        for (k = 0; k < 4; k++)
        begin
            @(posedge clk);
            if (k == 3)
                rst <= 1'b0;
            @(negedge clk);
            check_all_zero(errs);
        end
        report_test("reset state", errs);

        for (k = 0; k < n_runs; k++)
        begin
            run_countdown(gaps[k], errs, pulses);
            report_test($sformatf("countdown %0d (gap %0d, %0d extra starts)",
                                  k, gaps[k], pulses), errs);
        end

        report_test("row scan", row_err);
        report_test("glyph content", glyph_err);
        report_test("colour rule", colour_err);
        $display("summary: %0d tests passed, %0d tests failed", n_pass, n_fail);
        if (n_fail == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: sim/dz_testdata.txt
// columns: digit row red green, all hex, one glyph row per line
// after the 40 glyph rows: number of countdown runs, then the idle gap in cycles for each run
// digit 5, red only
5 0 00 00
5 1 7e 00
5 2 60 00
5 3 7c 00
5 4 06 00
5 5 06 00
5 6 66 00
5 7 3c 00
// digit 4, red only
4 0 00 00
4 1 0c 00
4 2 1c 00
4 3 2c 00
4 4 4c 00
4 5 7e 00
4 6 0c 00
4 7 0c 00
// digit 3, yellow
3 0 00 00
3 1 3c 3c
3 2 66 66
3 3 06 06
3 4 1c 1c
3 5 06 06
3 6 66 66
3 7 3c 3c
// digit 2, yellow
2 0 00 00
2 1 3c 3c
2 2 66 66
2 3 06 06
2 4 0c 0c
2 5 30 30
2 6 60 60
2 7 7e 7e
// digit 1, yellow
1 0 00 00
1 1 18 18
1 2 18 18
1 3 38 38
1 4 18 18
1 5 18 18
1 6 60 60
1 7 7e 7e
// countdown runs and gaps
4
3
a
19
0

// File: files.f
hw/dz_pkg.sv
hw/glyph_if.sv
hw/dz_glyph_rom.sv
hw/dz_show.sv
hw/countdown_seq.sv
hw/dz_countdown_top.sv
sim/tb_dz_countdown.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the countdown testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert \
        --top-module tb_dz_countdown \
        -Mdir obj_dir \
        -f files.f; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_dz_countdown)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF "*** TEST PASSED ***" <<< "$out"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1
